// ==== files.f ====
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/reg_file.sv
design/unified_ram.sv
design/cpu_sequencer.sv
design/cpu_top.sv
tb/tb_cpu.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_cpu

all: run

run: $(SIM)
	./$(SIM)

$(SIM): files.f design/*.sv design/*.svh tb/*.sv
	verilator --binary --timing --assert --top-module tb_cpu -f files.f

lint:
	verilator --lint-only --timing -Wall --top-module tb_cpu -f files.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu;
	import cpu_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int HOLD_CYCLES  = 8;
	localparam logic [31:0] SEED = 32'ha65f922e;

	logic                        clk;
	logic                        rst;
	logic                        load_en;
	logic [`CPU_MEM_ADDR_W-1:0]  load_addr;
	logic [`CPU_DATA_W-1:0]      load_data;
	logic                        run;
	logic                        wb_credit;
	logic                        halted;
	logic                        wb_valid;
	logic [`CPU_REG_IDX_W-1:0]   wb_reg;
	logic [`CPU_DATA_W-1:0]      wb_data;

	// Each table entry is a slice of these queues
	logic [`CPU_DATA_W-1:0]      code_q[$];
	logic [`CPU_MEM_ADDR_W-1:0]  pre_addr_q[$];
	logic [`CPU_DATA_W-1:0]      pre_data_q[$];
	logic [`CPU_REG_IDX_W-1:0]   exp_reg_q[$];
	logic [`CPU_DATA_W-1:0]      exp_val_q[$];
	int code_start[$];
	int pre_start[$];
	int beat_start[$];

	int entry = 0;
	int beat_base = 0;
	int beats_seen = 0;
	int limit_cycles = 0;

	cpu_top DUT (
		.clk       (clk),
		.rst       (rst),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.run       (run),
		.wb_credit (wb_credit),
		.halted    (halted),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// opcode, rd, rs, pad
	function automatic logic [15:0] rr_word(logic [3:0] op, int rd, int rs);
		return {op, 3'(rd), 3'(rs), 6'b0};
	endfunction

	// opcode, rd, pad, imm
	function automatic logic [15:0] ri_word(logic [3:0] op, int rd, logic [7:0] imm);
		return {op, 3'(rd), 1'b0, imm};
	endfunction

	task automatic stop_on_error();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(string what, logic [31:0] got, logic [31:0] expected);
		if (got !== expected) begin
			$display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, expected);
			stop_on_error();
		end
	endtask

	task automatic open_entry();
		code_start.push_back(code_q.size());
		pre_start.push_back(pre_addr_q.size());
		beat_start.push_back(exp_reg_q.size());
	endtask

	task automatic put_code(logic [15:0] word);
		code_q.push_back(word);
	endtask

	// Instruction that retires with one trace beat
	task automatic put_beat(logic [15:0] word, int r, logic [15:0] v);
		code_q.push_back(word);
		exp_reg_q.push_back(3'(r));
		exp_val_q.push_back(v);
	endtask

	task automatic preload_word(logic [`CPU_MEM_ADDR_W-1:0] addr, logic [15:0] data);
		pre_addr_q.push_back(addr);
		pre_data_q.push_back(data);
	endtask

	task automatic build_table();
		// LDI and the ALU operations
		open_entry();
		put_beat(ri_word(OP_LDI, 1, 8'h05), 1, 16'h0005);
		put_beat(ri_word(OP_LDI, 2, 8'h07), 2, 16'h0007);
		put_beat(rr_word(OP_ADD, 1, 2), 1, 16'h000c);
		// 7 - 12 wraps at 16 bits
		put_beat(rr_word(OP_SUB, 2, 1), 2, 16'hfffb);
		put_beat(rr_word(OP_AND, 2, 1), 2, 16'h0008);
		put_beat(ri_word(OP_LDI, 3, 8'hf0), 3, 16'h00f0);
		put_beat(rr_word(OP_OR, 3, 1), 3, 16'h00fc);
		put_beat(rr_word(OP_XOR, 3, 2), 3, 16'h00f4);
		put_code(rr_word(OP_HALT, 0, 0));
		put_code(ri_word(OP_LDI, 6, 8'h66));
		// Loads and stores in the data segment
		open_entry();
		preload_word(9'h120, 16'hbeef);
		preload_word(9'h106, 16'h1234);
		put_beat(ri_word(OP_LDI, 1, 8'h20), 1, 16'h0020);
		put_beat(rr_word(OP_LD, 2, 1), 2, 16'hbeef);
		put_beat(ri_word(OP_LDI, 3, 8'h06), 3, 16'h0006);
		// Data word 6 shares its offset with code word 6 below
		put_code(rr_word(OP_ST, 2, 3));
		put_beat(rr_word(OP_LD, 5, 3), 5, 16'hbeef);
		put_beat(rr_word(OP_XOR, 5, 1), 5, 16'hbecf);
		put_beat(ri_word(OP_LDI, 7, 8'h3c), 7, 16'h003c);
		put_code(rr_word(OP_HALT, 0, 0));
		// Branches taken to word 4, not taken, then taken to word 10
		open_entry();
		put_beat(ri_word(OP_LDI, 1, 8'h04), 1, 16'h0004);
		put_code(rr_word(OP_BEQZ, 1, 0));
		put_code(ri_word(OP_LDI, 2, 8'h99));
		put_code(ri_word(OP_LDI, 2, 8'h98));
		put_beat(ri_word(OP_LDI, 3, 8'h0a), 3, 16'h000a);
		put_code(rr_word(OP_BEQZ, 3, 1));
		put_beat(ri_word(OP_LDI, 4, 8'h55), 4, 16'h0055);
		put_beat(rr_word(OP_SUB, 4, 4), 4, 16'h0000);
		put_code(rr_word(OP_BEQZ, 3, 4));
		put_code(ri_word(OP_LDI, 5, 8'h77));
		// Undefined opcode stops like HALT
		put_code(rr_word(4'ha, 0, 0));
		put_code(ri_word(OP_LDI, 6, 8'h66));
		open_entry();
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Trace beats and idle outputs sampled on the falling edge
	always @(negedge clk) begin : trace_monitor
		int k;
		if (!rst && !run) begin
			check_value("wb_valid while stopped", 32'(wb_valid), 0);
			check_value("halted while stopped", 32'(halted), 0);
		end
		if (wb_valid) begin
			k = beats_seen - beat_base;
			if (k >= beat_start[entry + 1] - beat_start[entry]) begin
				$display("Unexpected trace beat on r%0d at time %0t", wb_reg, $time);
				stop_on_error();
			end else begin
				check_value("trace register", 32'(wb_reg),
					32'(exp_reg_q[beat_start[entry] + k]));
				check_value("trace data", 32'(wb_data),
					32'(exp_val_q[beat_start[entry] + k]));
				beats_seen = beats_seen + 1;
			end
		end
	end

	// Owed credits go back at random
	initial begin : credit_return
		int owed;
		int returned;
		logic [31:0] rnd;
		wb_credit = 1'b0;
		returned = 0;
		rnd = SEED;
		forever begin
			@(posedge clk);
			owed = beats_seen - returned;
			if (rst) begin
				wb_credit <= 1'b0;
				returned = beats_seen;
			end else begin
				check_value("beats beyond the credit grant",
					32'(owed > `CPU_TRACE_CREDITS), 0);
				rnd = xorshift32(rnd);
				if (owed > 0 && rnd[1:0] == 2'b00) begin
					wb_credit <= 1'b1;
					returned = returned + 1;
				end else begin
					wb_credit <= 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Watchdog expired: the program table did not finish in %0d cycles",
			limit_cycles);
		stop_on_error();
	end

	initial begin : main_seq
		int i;
		rst = 1'b1;
		run = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		build_table();
		limit_cycles = 8 * code_q.size() + 64 * exp_reg_q.size();
		for (int e = 0; e < code_start.size() - 1; e++) begin
			@(posedge clk);
			rst <= 1'b1;
			run <= 1'b0;
			repeat (RESET_CYCLES) @(posedge clk);
			rst <= 1'b0;
			entry = e;
			beat_base = beats_seen;
			// Code at the bottom of the code segment, then data preloads
			for (i = code_start[e]; i < code_start[e + 1]; i++) begin
				@(posedge clk);
				load_en <= 1'b1;
				load_addr <= {1'b0, 8'(i - code_start[e])};
				load_data <= code_q[i];
			end
			for (i = pre_start[e]; i < pre_start[e + 1]; i++) begin
				@(posedge clk);
				load_en <= 1'b1;
				load_addr <= pre_addr_q[i];
				load_data <= pre_data_q[i];
			end
			@(posedge clk);
			load_en <= 1'b0;
			@(posedge clk);
			run <= 1'b1;
			do
				@(negedge clk);
			while (!halted);
			check_value("beats before halt", beats_seen - beat_base,
				beat_start[e + 1] - beat_start[e]);
			repeat (HOLD_CYCLES) begin
				@(negedge clk);
				check_value("halted after halt", 32'(halted), 1);
			end
			check_value("beats after halt", beats_seen - beat_base,
				beat_start[e + 1] - beat_start[e]);
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        load_en,
	input  logic [`CPU_MEM_ADDR_W-1:0]  load_addr,
	input  logic [`CPU_DATA_W-1:0]      load_data,
	input  logic                        run,
	input  logic                        wb_credit,
	output logic                        halted,
	output logic                        wb_valid,
	output logic [`CPU_REG_IDX_W-1:0]   wb_reg,
	output logic [`CPU_DATA_W-1:0]      wb_data
);
	import cpu_pkg::*;

	// Memory port
	logic [`CPU_MEM_ADDR_W-1:0] mem_addr;
	logic                       mem_we;
	logic [`CPU_DATA_W-1:0]     mem_wdata;
	logic [`CPU_DATA_W-1:0]     mem_rdata;

	// Register file ports
	logic [`CPU_REG_IDX_W-1:0]  rd_idx_a;
	logic [`CPU_REG_IDX_W-1:0]  rd_idx_b;
	logic [`CPU_DATA_W-1:0]     rd_data_a;
	logic [`CPU_DATA_W-1:0]     rd_data_b;
	logic                       reg_we;
	logic [`CPU_REG_IDX_W-1:0]  reg_widx;
	logic [`CPU_DATA_W-1:0]     reg_wdata;

	// ALU
	op_t                        alu_op;
	logic [`CPU_DATA_W-1:0]     alu_result;
	logic                       alu_zero;

	cpu_sequencer u_seq (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.mem_rdata  (mem_rdata),
		.rd_data_a  (rd_data_a),
		.rd_data_b  (rd_data_b),
		.alu_result (alu_result),
		.alu_zero   (alu_zero),
		.wb_credit  (wb_credit),
		.mem_addr   (mem_addr),
		.mem_we     (mem_we),
		.mem_wdata  (mem_wdata),
		.rd_idx_a   (rd_idx_a),
		.rd_idx_b   (rd_idx_b),
		.alu_op     (alu_op),
		.reg_we     (reg_we),
		.reg_widx   (reg_widx),
		.reg_wdata  (reg_wdata),
		.halted     (halted),
		.wb_valid   (wb_valid),
		.wb_reg     (wb_reg),
		.wb_data    (wb_data)
	);

	reg_file u_regs (
		.clk       (clk),
		.rst       (rst),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.we        (reg_we),
		.widx      (reg_widx),
		.wdata     (reg_wdata),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	alu u_alu (
		.op     (alu_op),
		.a      (rd_data_a),
		.b      (rd_data_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	unified_ram u_ram (
		.clk       (clk),
		.run       (run),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.addr      (mem_addr),
		.we        (mem_we),
		.wdata     (mem_wdata),
		.rdata     (mem_rdata)
	);

endmodule

// ==== design/cpu_sequencer.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_sequencer (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        run,
	input  logic [`CPU_DATA_W-1:0]      mem_rdata,
	input  logic [`CPU_DATA_W-1:0]      rd_data_a,
	input  logic [`CPU_DATA_W-1:0]      rd_data_b,
	input  logic [`CPU_DATA_W-1:0]      alu_result,
	input  logic                        alu_zero,
	input  logic                        wb_credit,
	output logic [`CPU_MEM_ADDR_W-1:0]  mem_addr,
	output logic                        mem_we,
	output logic [`CPU_DATA_W-1:0]      mem_wdata,
	output logic [`CPU_REG_IDX_W-1:0]   rd_idx_a,
	output logic [`CPU_REG_IDX_W-1:0]   rd_idx_b,
	output cpu_pkg::op_t                alu_op,
	output logic                        reg_we,
	output logic [`CPU_REG_IDX_W-1:0]   reg_widx,
	output logic [`CPU_DATA_W-1:0]      reg_wdata,
	output logic                        halted,
	output logic                        wb_valid,
	output logic [`CPU_REG_IDX_W-1:0]   wb_reg,
	output logic [`CPU_DATA_W-1:0]      wb_data
);
	import cpu_pkg::*;

	localparam int CREDIT_W = $clog2(`CPU_TRACE_CREDITS + 1);

	localparam logic [2:0] S_IDLE      = 3'd0;
	localparam logic [2:0] S_FETCH     = 3'd1;
	localparam logic [2:0] S_DECODE    = 3'd2;
	localparam logic [2:0] S_EXECUTE   = 3'd3;
	localparam logic [2:0] S_MEMORY    = 3'd4;
	localparam logic [2:0] S_WRITEBACK = 3'd5;
	localparam logic [2:0] S_HALTED    = 3'd6;

	logic [2:0]                   state;
	logic [`CPU_SEG_OFFSET_W-1:0] pc;
	logic                         run_q;
	logic [CREDIT_W-1:0]          credits;
	instr_t                       ir;
	instr_t                       fetched;
	instr_t                       cur;
	op_t                          op;
	logic [`CPU_DATA_W-1:0]       result;
	logic                         data_access;

	assign fetched = mem_rdata;

	// In DECODE the word comes straight from memory, afterwards from the IR
	assign cur = (state == S_DECODE) ? fetched : ir;
	assign op  = ir.rr.opcode;

	// rd sits in the same bits of both views and rs exists only in RR
	assign rd_idx_a = cur.rr.rd;
	assign rd_idx_b = cur.rr.rs;
	assign alu_op   = op;

	// LD puts out its address in EXECUTE, ST writes in MEMORY
	assign data_access = (state == S_EXECUTE && op == OP_LD) ||
		(state == S_MEMORY && op == OP_ST);
	assign mem_addr  = data_access ? {1'b1, rd_data_b[`CPU_SEG_OFFSET_W-1:0]} : {1'b0, pc};
	assign mem_we    = (state == S_MEMORY) && (op == OP_ST);
	assign mem_wdata = rd_data_a;

	// Register write and trace beat share one cycle and need a credit
	assign wb_valid  = (state == S_WRITEBACK) && writes_reg(op) && (credits != '0);
	assign reg_we    = wb_valid;
	assign reg_widx  = ir.rr.rd;
	assign reg_wdata = result;
	assign wb_reg    = reg_widx;
	assign wb_data   = result;
	assign halted    = (state == S_HALTED);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			pc    <= '0;
			run_q <= 1'b0;
		end else begin
			run_q <= run;
			case (state)
				S_IDLE: begin
					if (run && !run_q) begin
						pc    <= '0;
						state <= S_FETCH;
					end
				end
				S_FETCH: state <= S_DECODE;
				S_DECODE: begin
					if (is_halt(fetched.rr.opcode))
						state <= S_HALTED;
					else if (fetched.rr.opcode == OP_ST)
						state <= S_MEMORY;
					else
						state <= S_EXECUTE;
				end
				S_EXECUTE: state <= (op == OP_LD) ? S_MEMORY : S_WRITEBACK;
				S_MEMORY: begin
					if (op == OP_LD) begin
						state <= S_WRITEBACK;
					end else begin
						pc    <= pc + 1'b1;
						state <= S_FETCH;
					end
				end
				S_WRITEBACK: begin
					// Branch target is rd, condition is rs == 0
					if (op == OP_BEQZ) begin
						pc    <= alu_zero ? rd_data_a[`CPU_SEG_OFFSET_W-1:0] : pc + 1'b1;
						state <= S_FETCH;
					end else if (credits != '0) begin
						pc    <= pc + 1'b1;
						state <= S_FETCH;
					end
				end
				S_HALTED: state <= S_HALTED;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Instruction word and result
	always_ff @(posedge clk) begin
		if (state == S_DECODE)
			ir <= fetched;
		if (state == S_EXECUTE) begin
			if (op == OP_LDI)
				result <= {{(`CPU_DATA_W-`CPU_SEG_OFFSET_W){1'b0}}, ir.ri.imm};
			else
				result <= alu_result;
		end
		if (state == S_MEMORY && op == OP_LD)
			result <= mem_rdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			credits <= CREDIT_W'(`CPU_TRACE_CREDITS);
		else
			credits <= credits - CREDIT_W'(wb_valid) + CREDIT_W'(wb_credit);
	end

	// Receiver must not return more credits than it was given
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= CREDIT_W'(`CPU_TRACE_CREDITS))
		else $error("trace credits above the reset grant");

	// A writing instruction without a credit holds in WRITEBACK
	a_stall_without_credit: assert property (@(posedge clk) disable iff (rst)
		(state == S_WRITEBACK && writes_reg(op) && credits == '0) |=>
			(state == S_WRITEBACK && $stable(pc)))
		else $error("writeback advanced without a trace credit");

endmodule

// ==== design/unified_ram.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module unified_ram (
	input  logic                        clk,
	input  logic                        run,
	input  logic                        load_en,
	input  logic [`CPU_MEM_ADDR_W-1:0]  load_addr,
	input  logic [`CPU_DATA_W-1:0]      load_data,
	input  logic [`CPU_MEM_ADDR_W-1:0]  addr,
	input  logic                        we,
	input  logic [`CPU_DATA_W-1:0]      wdata,
	output logic [`CPU_DATA_W-1:0]      rdata
);

	// Code segment in the lower half, data segment in the upper half
	logic [`CPU_DATA_W-1:0] mem [1 << `CPU_MEM_ADDR_W];

	always_ff @(posedge clk) begin
		// Program loader owns the array while the core is stopped
		if (!run && load_en)
			mem[load_addr] <= load_data;
		else if (run && we)
			mem[addr] <= wdata;
		// Read data one cycle after the address, old contents on a collision
		rdata <= mem[addr];
	end

	a_no_load_while_running: assert property (@(posedge clk)
		!(load_en && run))
		else $error("program load attempted while running");

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module reg_file (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`CPU_REG_IDX_W-1:0]  rd_idx_a,
	input  logic [`CPU_REG_IDX_W-1:0]  rd_idx_b,
	input  logic                       we,
	input  logic [`CPU_REG_IDX_W-1:0]  widx,
	input  logic [`CPU_DATA_W-1:0]     wdata,
	output logic [`CPU_DATA_W-1:0]     rd_data_a,
	output logic [`CPU_DATA_W-1:0]     rd_data_b
);

	logic [`CPU_DATA_W-1:0] regs [`CPU_REG_COUNT];

	// Write on the edge, all entries cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[widx] <= wdata;
		end
	end

	// Combinational reads
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

	a_widx_known: assert property (@(posedge clk) disable iff (rst)
		we |-> !$isunknown(widx))
		else $error("register write with unknown index");

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu (
	input  cpu_pkg::op_t                op,
	input  logic [`CPU_DATA_W-1:0]      a,
	input  logic [`CPU_DATA_W-1:0]      b,
	output logic [`CPU_DATA_W-1:0]      result,
	output logic                        zero
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			// Sum and difference wrap at the word width
			OP_ADD: result = a + b;
			OP_SUB: result = a - b;
			OP_AND: result = a & b;
			OP_OR:  result = a | b;
			OP_XOR: result = a ^ b;
			// Branch test looks at rs only
			OP_BEQZ: result = b;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== design/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

	typedef enum logic [`CPU_OPCODE_W-1:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_LDI  = 4'h5,
		OP_LD   = 4'h6,
		OP_ST   = 4'h7,
		OP_BEQZ = 4'h8,
		OP_HALT = 4'hf
	} op_t;

	// Register-register view
	typedef struct packed {
		op_t                                                   opcode;
		logic [`CPU_REG_IDX_W-1:0]                             rd;
		logic [`CPU_REG_IDX_W-1:0]                             rs;
		logic [`CPU_DATA_W-`CPU_OPCODE_W-2*`CPU_REG_IDX_W-1:0] pad;
	} instr_rr_t;

	// Register-immediate view
	typedef struct packed {
		op_t                       opcode;
		logic [`CPU_REG_IDX_W-1:0] rd;
		logic [`CPU_DATA_W-`CPU_OPCODE_W-`CPU_REG_IDX_W-`CPU_SEG_OFFSET_W-1:0] pad;
		logic [`CPU_SEG_OFFSET_W-1:0] imm;
	} instr_ri_t;

	typedef union packed {
		instr_rr_t rr;
		instr_ri_t ri;
	} instr_t;

	// Instructions that end with a register write and a trace beat
	function automatic logic writes_reg(op_t op);
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI, OP_LD: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Undefined codes stop the core as well
	function automatic logic is_halt(op_t op);
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: return 1'b0;
			OP_LDI, OP_LD, OP_ST, OP_BEQZ: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

endpackage

// ==== design/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data, register and instruction word width
`define CPU_DATA_W 16

// Register file depth
`define CPU_REG_COUNT 8

// Register index width follows the depth
`define CPU_REG_IDX_W ($clog2(`CPU_REG_COUNT))

// Unified memory, 512 words
`define CPU_MEM_ADDR_W 9

// Offset inside one segment; address MSB picks code (0) or data (1)
`define CPU_SEG_OFFSET_W 8

// Opcode field width
`define CPU_OPCODE_W 4

// Trace credits granted by the receiver after reset
`define CPU_TRACE_CREDITS 2

`endif
